/* Bender.yml */
package:
  name: hevc_encode_system_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/enc_pkg.sv
      - common/blk_cmd_if.sv
      - common/frame_slot_if.sv
      - verilog/blk_cmd_decode.sv
      - fdma_sched/fdma_sched.sv
      - verilog/frame_ring.sv
      - verilog/hevc_encode_system_ctrl.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/hevc_ctrl_props.sv
      - tb/tb_hevc_encode_system_ctrl.sv

/* common/blk_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface blk_cmd_if;
    import enc_pkg::*;

    logic       pending;
    logic       is_write;
    logic       use_recon;
    logic       is_chroma;
    row_cnt_t   row_limit;
    blk_coord_t first_row;
    blk_coord_t col;
    burst_len_t beats;
    // last row of the command has completed
    logic       finish;

    modport decoder (
        output pending, is_write, use_recon, is_chroma,
        output row_limit, first_row, col, beats,
        input  finish
    );

    modport sched (
        input  pending, is_write, use_recon, is_chroma,
        input  row_limit, first_row, col, beats,
        output finish
    );

endinterface

`default_nettype wire

/* common/enc_params.svh */
`ifndef ENC_PARAMS_SVH
`define ENC_PARAMS_SVH

// frame geometry, kept small so simulation stays short
`define FRAME_WIDTH 64
`define FRAME_HEIGHT 32

// luma plane size, chroma plane follows right after it
`define FRAME_SIZE (`FRAME_WIDTH * `FRAME_HEIGHT)

// bytes moved per FDMA beat
`define BURST_BYTES 16

// frames per group of pictures
`define GOP_LENGTH 4

// slot k starts at k * SLOT_STRIDE
// slot 0 holds the reconstruction, slots 1..3 take capture
`define SLOT_STRIDE 32'h0100_0000

`endif

/* common/enc_pkg.sv */
`default_nettype none

package enc_pkg;

    typedef logic [31:0] ddr_addr_t;
    typedef logic [15:0] burst_len_t;
    typedef logic [13:0] fifo_level_t;
    typedef logic [1:0]  slot_t;
    typedef logic [11:0] blk_coord_t;
    typedef logic [7:0]  blk_dim_t;
    typedef logic [7:0]  row_cnt_t;
    typedef logic [15:0] frame_cnt_t;

    // block transfer modes issued by the encoder core
    typedef enum logic [4:0] {
        LOAD_CUR_LUMA   = 5'd3,
        LOAD_CUR_CHROMA = 5'd5,
        LOAD_DB_LUMA    = 5'd7,
        LOAD_DB_CHROMA  = 5'd8,
        STORE_DB_LUMA   = 5'd9,
        STORE_DB_CHROMA = 5'd10
    } blk_mode_t;

    typedef enum logic [2:0] {
        SCHED_IDLE,
        SCHED_CAP_Y,
        SCHED_CAP_UV,
        SCHED_BLK,
        SCHED_WAIT
    } sched_state_t;

    typedef enum logic {
        INTRA = 1'b0,
        INTER = 1'b1
    } frame_type_t;

endpackage

`default_nettype wire

/* common/frame_slot_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface frame_slot_if;
    import enc_pkg::*;

    slot_t wr_slot;
    slot_t rd_slot;
    // luma plane of the write slot is complete
    logic  frame_done;
    logic  sched_idle;

    modport ring (
        output wr_slot, rd_slot,
        input  frame_done, sched_idle
    );

    modport sched (
        input  wr_slot, rd_slot,
        output frame_done, sched_idle
    );

endinterface

`default_nettype wire

/* fdma_sched/fdma_sched.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_params.svh"

module fdma_sched (
    input  logic                 clk_ui,
    input  logic                 rst_n_i,
    input  logic                 pixel_buffer_full_i,
    input  enc_pkg::fifo_level_t pixel_buffer_rd_cnt_i,
    input  logic                 fdma_busy_i,
    output logic                 pixel_type_o,
    output logic                 pixel_buffer_rd_en_o,
    output logic                 extif_rd_en_o,
    output logic                 extif_wr_en_o,
    output enc_pkg::ddr_addr_t   fdma_addr_o,
    output enc_pkg::burst_len_t  fdma_size_o,
    input  logic                 unsup_done_i,
    output logic                 hevc_extif_done_o,
    blk_cmd_if.sched             cmd,
    frame_slot_if.sched          slots
);
    import enc_pkg::*;

    sched_state_t state;
    sched_state_t issued;
    logic         seen_busy;
    logic         cap_pend;
    ddr_addr_t    y_count;
    ddr_addr_t    uv_addr;
    row_cnt_t     row_cnt;
    burst_len_t   remaining;
    burst_len_t   y_size;
    ddr_addr_t    row_addr;
    ddr_addr_t    launch_addr;
    burst_len_t   launch_size;
    logic         launch;
    logic         burst_end;
    logic         row_last;

    function automatic ddr_addr_t slot_base(input slot_t s);
        return ddr_addr_t'(s) * `SLOT_STRIDE;
    endfunction

    // luma beats left in the frame, Y size kept even so UV gets half
    assign remaining = burst_len_t'((`FRAME_SIZE - y_count) / `BURST_BYTES);
    assign y_size = (burst_len_t'(pixel_buffer_rd_cnt_i) >= remaining) ? remaining
                  : burst_len_t'({pixel_buffer_rd_cnt_i[13:1], 1'b0});

    assign row_addr = slot_base(cmd.use_recon ? slot_t'(0) : slots.rd_slot)
                    + (cmd.is_chroma ? ddr_addr_t'(`FRAME_SIZE) : ddr_addr_t'(0))
                    + (ddr_addr_t'(cmd.first_row) + ddr_addr_t'(row_cnt)) * `FRAME_WIDTH
                    + ddr_addr_t'(cmd.col);

    always_comb begin
        launch_addr = row_addr;
        launch_size = cmd.beats;
        case (state)
            SCHED_CAP_Y: begin
                launch_addr = slot_base(slots.wr_slot) + y_count;
                launch_size = y_size;
            end
            SCHED_CAP_UV: begin
                launch_addr = uv_addr;
                launch_size = fdma_size_o >> 1;
            end
            default: ;
        endcase
    end

    assign launch = !fdma_busy_i && ((state == SCHED_CAP_Y && y_size != '0)
                    || state == SCHED_CAP_UV || state == SCHED_BLK);
    // burst ends once busy has been seen high and then low
    assign burst_end = (state == SCHED_WAIT) && seen_busy && !fdma_busy_i;
    assign row_last  = (32'(row_cnt) + 1 == 32'(cmd.row_limit));

    // zero-row commands finish straight from idle
    assign cmd.finish = (burst_end && issued == SCHED_BLK && row_last)
                      || (state == SCHED_IDLE && !cap_pend && cmd.pending
                          && cmd.row_limit == '0);
    assign slots.sched_idle = (state == SCHED_IDLE) && !cap_pend && !cmd.pending;

    always_ff @(posedge clk_ui or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state                <= SCHED_IDLE;
            issued               <= SCHED_IDLE;
            seen_busy            <= 1'b0;
            cap_pend             <= 1'b0;
            y_count              <= '0;
            row_cnt              <= '0;
            pixel_type_o         <= 1'b0;
            pixel_buffer_rd_en_o <= 1'b0;
            extif_rd_en_o        <= 1'b0;
            extif_wr_en_o        <= 1'b0;
            fdma_addr_o          <= '0;
            fdma_size_o          <= '0;
            slots.frame_done     <= 1'b0;
            hevc_extif_done_o    <= 1'b0;
        end else begin
            pixel_buffer_rd_en_o <= 1'b0;
            extif_rd_en_o        <= 1'b0;
            extif_wr_en_o        <= 1'b0;
            slots.frame_done     <= 1'b0;
            hevc_extif_done_o    <= cmd.finish || unsup_done_i;

            // a full FIFO at the UV end keeps capture going
            if (pixel_buffer_full_i) begin
                cap_pend <= 1'b1;
            end else if (burst_end && issued == SCHED_CAP_UV) begin
                cap_pend <= 1'b0;
            end

            if (cmd.finish) begin
                row_cnt <= '0;
            end else if (burst_end && issued == SCHED_BLK) begin
                row_cnt <= row_cnt + 1'b1;
            end

            if (launch) begin
                issued      <= state;
                seen_busy   <= 1'b0;
                state       <= SCHED_WAIT;
                fdma_addr_o <= launch_addr;
                fdma_size_o <= launch_size;
                case (state)
                    SCHED_CAP_Y: begin
                        pixel_type_o         <= 1'b0;
                        pixel_buffer_rd_en_o <= 1'b1;
                        y_count <= y_count + ddr_addr_t'(y_size) * `BURST_BYTES;
                    end
                    SCHED_CAP_UV: begin
                        pixel_type_o         <= 1'b1;
                        pixel_buffer_rd_en_o <= 1'b1;
                    end
                    default: begin
                        extif_wr_en_o <= cmd.is_write;
                        extif_rd_en_o <= !cmd.is_write;
                    end
                endcase
            end else begin
                case (state)
                    SCHED_IDLE: begin
                        // capture first, then one block row
                        if (cap_pend) begin
                            state <= SCHED_CAP_Y;
                        end else if (cmd.pending && !cmd.finish) begin
                            state <= SCHED_BLK;
                        end
                    end
                    SCHED_WAIT: begin
                        if (fdma_busy_i) begin
                            seen_busy <= 1'b1;
                        end else if (seen_busy) begin
                            state <= (issued == SCHED_CAP_Y) ? SCHED_CAP_UV : SCHED_IDLE;
                            if (issued == SCHED_CAP_UV && y_count == `FRAME_SIZE) begin
                                slots.frame_done <= 1'b1;
                                y_count          <= '0;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // chroma target, taken from y_count before the Y burst advances it
    always_ff @(posedge clk_ui) begin
        if (launch && state == SCHED_CAP_Y) begin
            uv_addr <= slot_base(slots.wr_slot) + `FRAME_SIZE + (y_count >> 1);
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/enc_pkg.sv
common/blk_cmd_if.sv
common/frame_slot_if.sv
verilog/blk_cmd_decode.sv
fdma_sched/fdma_sched.sv
verilog/frame_ring.sv
verilog/hevc_encode_system_ctrl.sv
tb/hevc_ctrl_props.sv
tb/tb_hevc_encode_system_ctrl.sv

/* tb/hevc_ctrl_props.sv */
`timescale 1ns/1ps
`default_nettype none

module hevc_ctrl_props (
    input logic clk_ui,
    input logic rst_n_i,
    input logic pix_rd_en_i,
    input logic ext_rd_en_i,
    input logic ext_wr_en_i,
    input logic fdma_busy_i,
    input logic sys_start_i,
    input logic extif_done_i
);

    int fail_cnt = 0;

    // one FDMA user per start
    a_one_enable: assert property (@(posedge clk_ui) disable iff (!rst_n_i)
        $onehot0({pix_rd_en_i, ext_rd_en_i, ext_wr_en_i}))
    else begin
        $error("more than one FDMA enable high");
        fail_cnt++;
    end

    // start decided in a cycle with busy low
    a_start_not_busy: assert property (@(posedge clk_ui) disable iff (!rst_n_i)
        (pix_rd_en_i || ext_rd_en_i || ext_wr_en_i) |-> !$past(fdma_busy_i))
    else begin
        $error("FDMA start issued while busy");
        fail_cnt++;
    end

    a_sys_start_pulse: assert property (@(posedge clk_ui) disable iff (!rst_n_i)
        sys_start_i |=> !sys_start_i)
    else begin
        $error("encoder start longer than one cycle");
        fail_cnt++;
    end

    a_extif_done_pulse: assert property (@(posedge clk_ui) disable iff (!rst_n_i)
        extif_done_i |=> !extif_done_i)
    else begin
        $error("extif done longer than one cycle");
        fail_cnt++;
    end

endmodule

bind hevc_encode_system_ctrl hevc_ctrl_props u_hevc_ctrl_props (
    .clk_ui       (clk_ui),
    .rst_n_i      (rst_n_i),
    .pix_rd_en_i  (pixel_buffer_rd_en_o),
    .ext_rd_en_i  (extif_rd_en_o),
    .ext_wr_en_i  (extif_wr_en_o),
    .fdma_busy_i  (fdma_busy_i),
    .sys_start_i  (hevc_sys_start_o),
    .extif_done_i (hevc_extif_done_o)
);

`default_nettype wire

/* tb/tb_hevc_encode_system_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_params.svh"

module tb_hevc_encode_system_ctrl;
    import enc_pkg::*;

    localparam int TABLE_LEN = 7;
    // start, up to 5 busy cycles, turnaround
    localparam int BURST_CYC_MAX = 10;
    // every entry bounded by 8 rows plus the overlap entry and capture rounds
    localparam int WATCHDOG_CYC = ((TABLE_LEN + 2) * 8 + 16) * BURST_CYC_MAX + 400;

    // kind is 0 for capture, 1 for load and 2 for store
    typedef struct packed {
        logic [1:0] kind;
        logic       ptype;
        ddr_addr_t  addr;
        burst_len_t size;
    } burst_t;

    typedef struct packed {
        logic [4:0] mode;
        blk_coord_t x;
        blk_coord_t y;
        blk_dim_t   width;
        blk_dim_t   height;
        logic [7:0] exp_bursts;
    } blk_req_t;

    logic        clk_ui;
    logic        rst_n_i;
    logic        pixel_type_o;
    logic        pixel_buffer_rd_en_o;
    logic        pixel_buffer_full_i;
    fifo_level_t pixel_buffer_rd_cnt_i;
    logic        extif_wr_en_o;
    logic        extif_rd_en_o;
    ddr_addr_t   fdma_addr_o;
    burst_len_t  fdma_size_o;
    logic        fdma_busy_i;
    logic        hevc_sys_start_o;
    frame_type_t hevc_sys_type_o;
    logic        hevc_sys_done_i;
    logic        hevc_extif_start_i;
    logic        hevc_extif_done_o;
    blk_mode_t   hevc_extif_mode_i;
    blk_coord_t  hevc_extif_x_i;
    blk_coord_t  hevc_extif_y_i;
    blk_dim_t    hevc_extif_width_i;
    blk_dim_t    hevc_extif_height_i;

    burst_t   log_q[$];
    blk_req_t req_tab[TABLE_LEN];
    int       cap_levels[4] = '{37, 50, 17, 60};
    int       end_cnt = 0;
    int       done_cnt = 0;
    int       start_cnt = 0;
    int       mism_cnt = 0;
    int       other_cnt = 0;
    int       y_exp = 0;
    slot_t    rd_exp = 0;
    logic     busy_q = 1'b0;
    int       cyc = 0;
    int       end_cyc = 0;
    int       done_cyc = 0;

    hevc_encode_system_ctrl u_hevc_encode_system_ctrl (.*);

    always #5 clk_ui = ~clk_ui;

    // FDMA model holds busy for 2 to 5 cycles per start
    always @(posedge clk_ui) begin : fdma_model
        int unsigned busy_len;
        if (pixel_buffer_rd_en_o || extif_rd_en_o || extif_wr_en_o) begin
            busy_len = 2 + $urandom % 4;
            #1 fdma_busy_i = 1'b1;
            repeat (busy_len) @(posedge clk_ui);
            #1 fdma_busy_i = 1'b0;
        end
    end

    // records every start and counts burst ends and pulses
    always @(posedge clk_ui) begin : monitor
        burst_t seen;
        if (rst_n_i) begin
            cyc++;
            if (pixel_buffer_rd_en_o || extif_rd_en_o || extif_wr_en_o) begin
                seen.kind  = pixel_buffer_rd_en_o ? 2'd0 : (extif_wr_en_o ? 2'd2 : 2'd1);
                seen.ptype = pixel_type_o;
                seen.addr  = fdma_addr_o;
                seen.size  = fdma_size_o;
                log_q.push_back(seen);
            end
            if (busy_q && !fdma_busy_i) begin
                end_cnt++;
                end_cyc = cyc;
            end
            busy_q = fdma_busy_i;
            if (hevc_extif_done_o) begin
                done_cnt++;
                done_cyc = cyc;
            end
            if (hevc_sys_start_o) begin
                start_cnt++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYC * 10);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 WATCHDOG_CYC);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic next_cycle;
        @(posedge clk_ui);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            mism_cnt++;
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            other_cnt++;
        end
    endtask

    // wait until n starts have been seen and every burst has ended
    task automatic wait_bursts(input int n);
        while (log_q.size() < n || end_cnt < log_q.size()) begin
            next_cycle();
        end
    endtask

    // {known, write, recon, chroma} from the raw mode code
    function automatic logic [3:0] mode_flags(input logic [4:0] mode);
        case (mode)
            5'd3:    return 4'b1000;
            5'd5:    return 4'b1001;
            5'd7:    return 4'b1010;
            5'd8:    return 4'b1011;
            5'd9:    return 4'b1110;
            5'd10:   return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic ddr_addr_t slot_addr(input slot_t slot);
        return ddr_addr_t'(slot) * `SLOT_STRIDE;
    endfunction

    // one capture round against the luma progress of the frame
    task automatic check_cap_pair(input burst_t y, input burst_t uv, input int level,
                                  input slot_t slot);
        int        remaining;
        int        ysz;
        ddr_addr_t base;
        remaining = (`FRAME_SIZE - y_exp) / `BURST_BYTES;
        ysz       = (level >= remaining) ? remaining : (level / 2) * 2;
        base      = slot_addr(slot);
        check_val("pixel_type_o (Y)", y.ptype, 0);
        check_val("fdma_addr_o (Y)", y.addr, base + y_exp);
        check_val("fdma_size_o (Y)", y.size, ysz);
        check_val("pixel_type_o (UV)", uv.ptype, 1);
        check_val("fdma_addr_o (UV)", uv.addr, base + `FRAME_SIZE + y_exp / 2);
        check_val("fdma_size_o (UV)", uv.size, ysz / 2);
        y_exp += ysz * `BURST_BYTES;
        if (y_exp == `FRAME_SIZE) begin
            y_exp = 0;
        end
    endtask

    task automatic capture_round(input int level, input slot_t slot);
        int n0;
        n0 = log_q.size();
        pixel_buffer_rd_cnt_i = fifo_level_t'(level);
        pixel_buffer_full_i   = 1'b1;
        next_cycle();
        pixel_buffer_full_i = 1'b0;
        wait_bursts(n0 + 2);
        check_val("capture burst kinds", {log_q[n0].kind, log_q[n0 + 1].kind}, 0);
        check_cap_pair(log_q[n0], log_q[n0 + 1], level, slot);
    endtask

    // block request with an optional capture round requested mid-transfer
    task automatic run_block(input blk_req_t req, input int cap_level, input slot_t cap_slot);
        logic [3:0] flags;
        int         n0;
        int         d0;
        int         i;
        int         r;
        int         caps;
        int         start_cyc;
        slot_t      slot;
        blk_coord_t first;
        burst_t     b;
        flags = mode_flags(req.mode);
        slot  = flags[1] ? slot_t'(0) : rd_exp;
        first = flags[0] ? (req.y >> 1) : req.y;
        n0    = log_q.size();
        d0    = done_cnt;
        hevc_extif_mode_i   = blk_mode_t'(req.mode);
        hevc_extif_x_i      = req.x;
        hevc_extif_y_i      = req.y;
        hevc_extif_width_i  = req.width;
        hevc_extif_height_i = req.height;
        hevc_extif_start_i  = 1'b1;
        next_cycle();
        hevc_extif_start_i = 1'b0;
        start_cyc          = cyc;
        if (cap_level > 0) begin
            while (log_q.size() < n0 + 2) begin
                next_cycle();
            end
            pixel_buffer_rd_cnt_i = fifo_level_t'(cap_level);
            pixel_buffer_full_i   = 1'b1;
            next_cycle();
            pixel_buffer_full_i = 1'b0;
        end
        while (done_cnt == d0) begin
            next_cycle();
        end
        expect_true(end_cnt == log_q.size(), "extif done came before the last row completed");
        if (flags[3]) begin
            expect_true(done_cyc == end_cyc + 1,
                        "extif done not one cycle after the last row completed");
        end else begin
            expect_true(done_cyc == start_cyc + 2,
                        "extif done not two cycles after the unsupported start");
        end
        repeat (3) next_cycle();
        check_val("hevc_extif_done_o pulses", done_cnt - d0, 1);
        i    = n0;
        r    = 0;
        caps = 0;
        while (i < log_q.size()) begin
            b = log_q[i];
            if (b.kind == 2'd0) begin
                if (b.ptype == 1'b0 && i + 1 < log_q.size() && log_q[i + 1].kind == 2'd0) begin
                    check_cap_pair(b, log_q[i + 1], cap_level, cap_slot);
                    caps++;
                    i += 2;
                end else begin
                    expect_true(1'b0, "capture burst not issued as a luma and chroma pair");
                    i++;
                end
            end else begin
                check_val("extif direction", b.kind, flags[2] ? 2 : 1);
                check_val("fdma_addr_o (row)", b.addr, slot_addr(slot)
                          + (flags[0] ? `FRAME_SIZE : 0)
                          + (ddr_addr_t'(first) + r) * `FRAME_WIDTH + req.x);
                check_val("fdma_size_o (row)", b.size, req.width / `BURST_BYTES);
                r++;
                i++;
            end
        end
        check_val("block rows", r, req.exp_bursts);
        check_val("capture rounds", caps, (cap_level > 0) ? 1 : 0);
    endtask

    // intra first and then inter up to the GOP length
    task automatic gop_sequence;
        frame_type_t exp_type;
        int          cnt;
        exp_type = INTRA;
        cnt      = 0;
        check_val("hevc_sys_type_o", hevc_sys_type_o, exp_type);
        for (int k = 0; k < 4; k++) begin
            hevc_sys_done_i = 1'b1;
            next_cycle();
            hevc_sys_done_i = 1'b0;
            if (cnt < `GOP_LENGTH - 1) begin
                exp_type = INTER;
                cnt++;
            end else begin
                exp_type = INTRA;
                cnt      = 0;
            end
            check_val("hevc_sys_type_o", hevc_sys_type_o, exp_type);
            repeat (3) next_cycle();
        end
    endtask

    initial begin
        void'($urandom(32'h48f0));
        clk_ui                = 1'b0;
        rst_n_i               = 1'b0;
        pixel_buffer_full_i   = 1'b0;
        pixel_buffer_rd_cnt_i = '0;
        fdma_busy_i           = 1'b0;
        hevc_sys_done_i       = 1'b0;
        hevc_extif_start_i    = 1'b0;
        hevc_extif_mode_i     = LOAD_CUR_LUMA;
        hevc_extif_x_i        = '0;
        hevc_extif_y_i        = '0;
        hevc_extif_width_i    = '0;
        hevc_extif_height_i   = '0;
        req_tab = '{
            '{LOAD_CUR_LUMA,   12'd16, 12'd8,  8'd32, 8'd4, 8'd4},
            '{LOAD_CUR_CHROMA, 12'd0,  12'd8,  8'd16, 8'd8, 8'd4},
            '{LOAD_DB_LUMA,    12'd32, 12'd0,  8'd32, 8'd2, 8'd2},
            '{LOAD_DB_CHROMA,  12'd16, 12'd16, 8'd16, 8'd4, 8'd2},
            '{STORE_DB_LUMA,   12'd48, 12'd24, 8'd16, 8'd3, 8'd3},
            '{STORE_DB_CHROMA, 12'd0,  12'd2,  8'd64, 8'd6, 8'd3},
            '{5'd1,            12'd0,  12'd0,  8'd16, 8'd4, 8'd0}
        };
        repeat (16) @(posedge clk_ui);
        #1 rst_n_i = 1'b1;
        next_cycle();

        check_val("enables", {pixel_buffer_rd_en_o, extif_rd_en_o, extif_wr_en_o}, 0);
        check_val("hevc_sys_start_o", hevc_sys_start_o, 0);
        check_val("hevc_extif_done_o", hevc_extif_done_o, 0);
        check_val("fdma_addr_o", fdma_addr_o, 0);
        check_val("fdma_size_o", fdma_size_o, 0);
        check_val("hevc_sys_type_o", hevc_sys_type_o, INTRA);

        // first frame into slot 1 and the encoder starts once it is complete
        foreach (cap_levels[i]) begin
            capture_round(cap_levels[i], slot_t'(1));
            repeat (4) next_cycle();
            check_val("hevc_sys_start_o pulses", start_cnt, (i == 3) ? 1 : 0);
        end
        rd_exp = slot_t'(1);

        for (int i = 0; i < TABLE_LEN; i++) begin
            run_block(req_tab[i], 0, slot_t'(0));
        end

        // second frame lands in slot 2 between rows of a load
        run_block('{LOAD_CUR_LUMA, 12'd32, 12'd16, 8'd16, 8'd8, 8'd8}, 200, slot_t'(2));
        repeat (4) next_cycle();
        check_val("hevc_sys_start_o pulses", start_cnt, 1);

        // first done frees the encoder for the frame in slot 2
        gop_sequence();
        check_val("hevc_sys_start_o pulses", start_cnt, 2);

        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mism_cnt, other_cnt, u_hevc_encode_system_ctrl.u_hevc_ctrl_props.fail_cnt);
        if (mism_cnt + other_cnt + u_hevc_encode_system_ctrl.u_hevc_ctrl_props.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/blk_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_params.svh"

module blk_cmd_decode (
    input  logic                clk_ui,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  enc_pkg::blk_mode_t  mode_i,
    input  enc_pkg::blk_coord_t x_i,
    input  enc_pkg::blk_coord_t y_i,
    input  enc_pkg::blk_dim_t   width_i,
    input  enc_pkg::blk_dim_t   height_i,
    blk_cmd_if.decoder          cmd,
    output logic                unsup_done_o
);
    import enc_pkg::*;

    logic mode_known;
    logic dec_write;
    logic dec_recon;
    logic dec_chroma;

    // mode to direction, buffer and plane
    always_comb begin
        mode_known = 1'b1;
        dec_write  = 1'b0;
        dec_recon  = 1'b0;
        dec_chroma = 1'b0;
        case (mode_i)
            LOAD_CUR_LUMA: ;
            LOAD_CUR_CHROMA: dec_chroma = 1'b1;
            LOAD_DB_LUMA: dec_recon = 1'b1;
            LOAD_DB_CHROMA: begin
                dec_recon  = 1'b1;
                dec_chroma = 1'b1;
            end
            STORE_DB_LUMA: begin
                dec_write = 1'b1;
                dec_recon = 1'b1;
            end
            STORE_DB_CHROMA: begin
                dec_write  = 1'b1;
                dec_recon  = 1'b1;
                dec_chroma = 1'b1;
            end
            default: mode_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk_ui or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmd.pending  <= 1'b0;
            unsup_done_o <= 1'b0;
        end else begin
            unsup_done_o <= start_i && !mode_known;
            if (start_i && mode_known) begin
                cmd.pending <= 1'b1;
            end else if (cmd.finish) begin
                cmd.pending <= 1'b0;
            end
        end
    end

    // command geometry, held until the next request
    always_ff @(posedge clk_ui) begin
        if (start_i) begin
            cmd.is_write  <= dec_write;
            cmd.use_recon <= dec_recon;
            cmd.is_chroma <= dec_chroma;
            // chroma plane is half height
            cmd.row_limit <= dec_chroma ? row_cnt_t'(height_i >> 1) : row_cnt_t'(height_i);
            cmd.first_row <= dec_chroma ? (y_i >> 1) : y_i;
            cmd.col       <= x_i;
            cmd.beats     <= burst_len_t'(width_i / `BURST_BYTES);
        end
    end

endmodule

`default_nettype wire

/* verilog/frame_ring.sv */
`timescale 1ns/1ps
`default_nettype none
`include "enc_params.svh"

module frame_ring (
    input  logic                 clk_ui,
    input  logic                 rst_n_i,
    input  logic                 hevc_sys_done_i,
    output logic                 hevc_sys_start_o,
    output enc_pkg::frame_type_t hevc_sys_type_o,
    frame_slot_if.ring           slots
);
    import enc_pkg::*;

    slot_t      prev_wr;
    slot_t      next_wr;
    logic       enc_busy;
    logic       enc_go;
    frame_cnt_t frame_cnt;

    // lowest capture slot not in use for writing or encoding
    always_comb begin
        next_wr = slots.wr_slot;
        for (int k = 3; k >= 1; k--) begin
            if (slot_t'(k) != slots.wr_slot && slot_t'(k) != slots.rd_slot) begin
                next_wr = slot_t'(k);
            end
        end
    end

    // hold off while the ring rotates
    assign enc_go = slots.sched_idle && !enc_busy && !slots.frame_done
                 && prev_wr != '0 && prev_wr != slots.rd_slot;

    always_ff @(posedge clk_ui or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slots.wr_slot    <= slot_t'(1);
            slots.rd_slot    <= '0;
            prev_wr          <= '0;
            enc_busy         <= 1'b0;
            hevc_sys_start_o <= 1'b0;
            hevc_sys_type_o  <= INTRA;
            frame_cnt        <= '0;
        end else begin
            hevc_sys_start_o <= enc_go;

            // newest complete frame becomes the read slot
            if (enc_go) begin
                slots.rd_slot <= prev_wr;
                enc_busy      <= 1'b1;
            end else if (hevc_sys_done_i) begin
                enc_busy <= 1'b0;
            end

            if (slots.frame_done) begin
                prev_wr       <= slots.wr_slot;
                slots.wr_slot <= next_wr;
            end

            // first frame of each GOP is intra
            if (hevc_sys_done_i) begin
                if (frame_cnt < frame_cnt_t'(`GOP_LENGTH - 1)) begin
                    hevc_sys_type_o <= INTER;
                    frame_cnt       <= frame_cnt + 1'b1;
                end else begin
                    hevc_sys_type_o <= INTRA;
                    frame_cnt       <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/hevc_encode_system_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module hevc_encode_system_ctrl (
    input  logic                 clk_ui,
    input  logic                 rst_n_i,
    // pixel FIFO
    output logic                 pixel_type_o,
    output logic                 pixel_buffer_rd_en_o,
    input  logic                 pixel_buffer_full_i,
    input  enc_pkg::fifo_level_t pixel_buffer_rd_cnt_i,
    // FDMA
    output logic                 extif_wr_en_o,
    output logic                 extif_rd_en_o,
    output enc_pkg::ddr_addr_t   fdma_addr_o,
    output enc_pkg::burst_len_t  fdma_size_o,
    input  logic                 fdma_busy_i,
    // encoder core
    output logic                 hevc_sys_start_o,
    output enc_pkg::frame_type_t hevc_sys_type_o,
    input  logic                 hevc_sys_done_i,
    input  logic                 hevc_extif_start_i,
    output logic                 hevc_extif_done_o,
    input  enc_pkg::blk_mode_t   hevc_extif_mode_i,
    input  enc_pkg::blk_coord_t  hevc_extif_x_i,
    input  enc_pkg::blk_coord_t  hevc_extif_y_i,
    input  enc_pkg::blk_dim_t    hevc_extif_width_i,
    input  enc_pkg::blk_dim_t    hevc_extif_height_i
);

    logic unsup_done;

    blk_cmd_if    u_blk_cmd_if ();
    frame_slot_if u_frame_slot_if ();

    blk_cmd_decode u_blk_cmd_decode (
        .clk_ui       (clk_ui),
        .rst_n_i      (rst_n_i),
        .start_i      (hevc_extif_start_i),
        .mode_i       (hevc_extif_mode_i),
        .x_i          (hevc_extif_x_i),
        .y_i          (hevc_extif_y_i),
        .width_i      (hevc_extif_width_i),
        .height_i     (hevc_extif_height_i),
        .cmd          (u_blk_cmd_if.decoder),
        .unsup_done_o (unsup_done)
    );

    fdma_sched u_fdma_sched (
        .clk_ui                (clk_ui),
        .rst_n_i               (rst_n_i),
        .pixel_buffer_full_i   (pixel_buffer_full_i),
        .pixel_buffer_rd_cnt_i (pixel_buffer_rd_cnt_i),
        .fdma_busy_i           (fdma_busy_i),
        .pixel_type_o          (pixel_type_o),
        .pixel_buffer_rd_en_o  (pixel_buffer_rd_en_o),
        .extif_rd_en_o         (extif_rd_en_o),
        .extif_wr_en_o         (extif_wr_en_o),
        .fdma_addr_o           (fdma_addr_o),
        .fdma_size_o           (fdma_size_o),
        .unsup_done_i          (unsup_done),
        .hevc_extif_done_o     (hevc_extif_done_o),
        .cmd                   (u_blk_cmd_if.sched),
        .slots                 (u_frame_slot_if.sched)
    );

    frame_ring u_frame_ring (
        .clk_ui           (clk_ui),
        .rst_n_i          (rst_n_i),
        .hevc_sys_done_i  (hevc_sys_done_i),
        .hevc_sys_start_o (hevc_sys_start_o),
        .hevc_sys_type_o  (hevc_sys_type_o),
        .slots            (u_frame_slot_if.ring)
    );

endmodule

`default_nettype wire
